/* pid_subsystem.f */
+incdir+design
design/pid_pkg.sv
design/pid_control_unit.sv
design/pid_core.sv
design/pid_subsystem.sv
verif/pid_tb.sv

/* Bender.yml */
package:
  name: pid_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pid_pkg.sv
      - design/pid_control_unit.sv
      - design/pid_core.sv
      - design/pid_subsystem.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/pid_tb.sv

/* verif/pid_tb.sv */
////////////////////////////////////////////////////////////
// Directed testbench for pid_subsystem
// Inputs change on falling edges, outputs are sampled there
// Expected PID results come from a local model of the rule
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pid_settings.svh"

module pid_tb;

    localparam int DW = `PID_DATA_WIDTH;
    localparam int TIMEOUT = 50;

    logic              clock;
    logic              reset;
    logic [31:0]       sb_address;
    logic [31:0]       sb_write_data;
    logic              sb_write_strobe;
    logic              sb_read_strobe;
    logic [31:0]       sb_read_data;
    logic              sb_read_valid;
    logic              sb_ready;
    pid_pkg::sample_t  setpoint;
    pid_pkg::sample_t  measurement;
    logic              sample_req;
    logic              sample_ack;
    pid_pkg::sample_t  result;
    logic              result_req;
    logic              result_ack;

    int     value_errors = 0;
    int     timeout_errors = 0;
    integer seed = 32'hcc60;

    // Model copies of the parameters and controller state
    pid_pkg::gain_t    m_kp, m_ki, m_kd;
    pid_pkg::shift_t   m_kp_den, m_ki_den, m_kd_den;
    pid_pkg::sample_t  m_out_up, m_out_down, m_int_up, m_int_down;
    longint            m_integrator = 0;
    longint            m_prev_error = 0;

    pid_subsystem u_dut (
        .clock           (clock),
        .reset           (reset),
        .sb_address      (sb_address),
        .sb_write_data   (sb_write_data),
        .sb_write_strobe (sb_write_strobe),
        .sb_read_strobe  (sb_read_strobe),
        .sb_read_data    (sb_read_data),
        .sb_read_valid   (sb_read_valid),
        .sb_ready        (sb_ready),
        .setpoint        (setpoint),
        .measurement     (measurement),
        .sample_req      (sample_req),
        .sample_ack      (sample_ack),
        .result          (result),
        .result_req      (result_req),
        .result_ack      (result_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_sample(input string name, input pid_pkg::sample_t expected,
                                input pid_pkg::sample_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while %s", what);
        timeout_errors++;
    endtask

    task automatic wait_bus_ready();
        int n;
        n = 0;
        while (!sb_ready && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (!sb_ready) report_timeout("waiting for sb_ready");
    endtask

    // Also checks that sb_ready stays low for two cycles
    task automatic bus_write(input logic [31:0] offset, input logic [31:0] data);
        int low;
        wait_bus_ready();
        sb_address      = `PID_BASE_ADDRESS + offset;
        sb_write_data   = data;
        sb_write_strobe = 1'b1;
        @(negedge clock);
        sb_write_strobe = 1'b0;
        low = 0;
        while (!sb_ready && low < TIMEOUT) begin
            @(negedge clock);
            low++;
        end
        if (!sb_ready) report_timeout("waiting for a write to finish");
        check_count($sformatf("write 0x%02h ready low", offset), 2, low);
    endtask

    task automatic bus_read(input logic [31:0] offset, output logic [31:0] data);
        int n;
        wait_bus_ready();
        sb_address     = `PID_BASE_ADDRESS + offset;
        sb_read_strobe = 1'b1;
        @(negedge clock);
        sb_read_strobe = 1'b0;
        n = 0;
        while (!sb_read_valid && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (!sb_read_valid) report_timeout("waiting for sb_read_valid");
        check_count($sformatf("read 0x%02h valid delay", offset), 0, n);
        data = sb_read_data;
    endtask

    // Readback per the register map extension rules
    function automatic logic [31:0] expected_readback(input logic [31:0] offset,
                                                      input logic [31:0] data);
        case (offset)
            pid_pkg::REG_FLAG: return {31'd0, data[0]};
            pid_pkg::REG_KP, pid_pkg::REG_KI, pid_pkg::REG_KD:
                return 32'(data[DW-1:0]);
            pid_pkg::REG_LIMIT_OUT_UP, pid_pkg::REG_LIMIT_OUT_DOWN,
            pid_pkg::REG_LIMIT_INT_UP, pid_pkg::REG_LIMIT_INT_DOWN:
                return 32'(signed'(data[DW-1:0]));
            pid_pkg::REG_DEN: return {8'd0, data[23:0]};
            default: return 32'd0;
        endcase
    endfunction

    task automatic set_params(input pid_pkg::gain_t kp, input pid_pkg::gain_t ki,
                              input pid_pkg::gain_t kd, input pid_pkg::shift_t kp_den,
                              input pid_pkg::shift_t ki_den, input pid_pkg::shift_t kd_den);
        bus_write(pid_pkg::REG_KP, 32'(kp));
        bus_write(pid_pkg::REG_KI, 32'(ki));
        bus_write(pid_pkg::REG_KD, 32'(kd));
        bus_write(pid_pkg::REG_DEN, {8'd0, kd_den, ki_den, kp_den});
        m_kp = kp;
        m_ki = ki;
        m_kd = kd;
        m_kp_den = kp_den;
        m_ki_den = ki_den;
        m_kd_den = kd_den;
    endtask

    task automatic set_limits(input pid_pkg::sample_t out_up, input pid_pkg::sample_t out_down,
                              input pid_pkg::sample_t int_up, input pid_pkg::sample_t int_down);
        bus_write(pid_pkg::REG_LIMIT_OUT_UP, 32'(out_up));
        bus_write(pid_pkg::REG_LIMIT_OUT_DOWN, 32'(out_down));
        bus_write(pid_pkg::REG_LIMIT_INT_UP, 32'(int_up));
        bus_write(pid_pkg::REG_LIMIT_INT_DOWN, 32'(int_down));
        m_out_up = out_up;
        m_out_down = out_down;
        m_int_up = int_up;
        m_int_down = int_down;
    endtask

    task automatic model_step(input pid_pkg::sample_t sp, input pid_pkg::sample_t meas,
                              output pid_pkg::sample_t expected);
        longint err;
        longint p;
        longint d;
        longint integ;
        longint sum;
        err = longint'(sp) - longint'(meas);
        p = (longint'(m_kp) * err) >>> m_kp_den;
        d = (longint'(m_kd) * (err - m_prev_error)) >>> m_kd_den;
        integ = m_integrator + ((longint'(m_ki) * err) >>> m_ki_den);
        if (integ > longint'(m_int_up)) integ = m_int_up;
        else if (integ < longint'(m_int_down)) integ = m_int_down;
        sum = p + integ + d;
        if (sum > longint'(m_out_up)) sum = m_out_up;
        else if (sum < longint'(m_out_down)) sum = m_out_down;
        m_integrator = integ;
        m_prev_error = err;
        expected = pid_pkg::sample_t'(sum);
    endtask

    task automatic acknowledge_result();
        int n;
        result_ack = 1'b1;
        n = 0;
        while (result_req && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (result_req) report_timeout("waiting for result_req to fall");
        result_ack = 1'b0;
    endtask

    task automatic run_sample(input pid_pkg::sample_t sp, input pid_pkg::sample_t meas,
                              input bit ack, output pid_pkg::sample_t res, output int latency);
        int n;
        n = 0;
        while (sample_ack && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (sample_ack) report_timeout("waiting for sample_ack to fall");
        setpoint    = sp;
        measurement = meas;
        sample_req  = 1'b1;
        n = 0;
        while (!sample_ack && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (!sample_ack) report_timeout("waiting for sample_ack");
        sample_req = 1'b0;
        latency = 0;
        while (!result_req && latency < TIMEOUT) begin
            @(negedge clock);
            latency++;
        end
        if (!result_req) report_timeout("waiting for result_req");
        res = result;
        if (ack) acknowledge_result();
    endtask

    task automatic drive_and_compare(input string name, input pid_pkg::sample_t sp,
                                     input pid_pkg::sample_t meas, input bit nonblocking,
                                     output pid_pkg::sample_t res);
        pid_pkg::sample_t expected;
        int latency;
        model_step(sp, meas, expected);
        run_sample(sp, meas, !nonblocking, res, latency);
        check_sample(name, expected, res);
        check_count({name, " latency"}, 3, latency);
        if (nonblocking) begin
            @(negedge clock);
            check_count({name, " pulse"}, 0, int'(result_req));
        end
    endtask

    task automatic read_and_check(input string name, input logic [31:0] offset,
                                  input logic [31:0] expected);
        logic [31:0] actual;
        bus_read(offset, actual);
        check_word(name, expected, actual);
    endtask

    task automatic read_reset_values();
        check_sample("reset result", 0, result);
        check_count("reset result_req", 0, int'(result_req));
        check_count("reset sample_ack", 0, int'(sample_ack));
        read_and_check("reset flag", pid_pkg::REG_FLAG, 32'd0);
        read_and_check("reset kp", pid_pkg::REG_KP, 32'd0);
        read_and_check("reset ki", pid_pkg::REG_KI, 32'd0);
        read_and_check("reset kd", pid_pkg::REG_KD, 32'd0);
        read_and_check("reset out up", pid_pkg::REG_LIMIT_OUT_UP, 32'(`PID_LIMIT_MAX));
        read_and_check("reset out down", pid_pkg::REG_LIMIT_OUT_DOWN, 32'(-`PID_LIMIT_MAX));
        read_and_check("reset int up", pid_pkg::REG_LIMIT_INT_UP, 32'(`PID_LIMIT_MAX));
        read_and_check("reset int down", pid_pkg::REG_LIMIT_INT_DOWN, 32'(-`PID_LIMIT_MAX));
        read_and_check("reset den", pid_pkg::REG_DEN, 32'd0);
        read_and_check("reset unknown", 32'h24, 32'd0);
    endtask

    task automatic sweep_register_map();
        logic [31:0] data;
        for (int off = 0; off <= 36; off += 4) begin
            data = $random(seed);
            bus_write(off, data);
            read_and_check($sformatf("register map 0x%02h", off), off,
                           expected_readback(off, data));
        end
    endtask

    task automatic run_p_and_d_paths();
        pid_pkg::sample_t res;
        pid_pkg::shift_t  dens [3] = '{8'd0, 8'd2, 8'd5};
        bus_write(pid_pkg::REG_FLAG, 32'd0);
        set_limits(`PID_LIMIT_MAX, -`PID_LIMIT_MAX, `PID_LIMIT_MAX, -`PID_LIMIT_MAX);
        foreach (dens[i]) begin
            set_params($random(seed) & 32'hff, 0, $random(seed) & 32'hff,
                       dens[i], 0, dens[i] + 1);
            repeat (4) begin
                drive_and_compare($sformatf("p and d den %0d", dens[i]),
                                  $random(seed) % 4000, $random(seed) % 4000, 1'b0, res);
            end
        end
    endtask

    task automatic saturate_integrator();
        pid_pkg::sample_t res;
        set_limits(2000, -2000, 1000, -1000);
        set_params(0, 300, 0, 0, 0, 0);
        repeat (5) drive_and_compare("integrator rise", 100, 0, 1'b0, res);
        check_sample("integrator limit up", 1000, res);
        repeat (3) drive_and_compare("integrator fall", 0, 100, 1'b0, res);
        check_sample("integrator limit down", -1000, res);
        // Output limits tighter than the integrator
        set_limits(500, -500, 1000, -1000);
        set_params(2, 300, 0, 0, 0, 0);
        drive_and_compare("output clamp low", 0, 100, 1'b0, res);
        check_sample("output limit down", -500, res);
        repeat (2) drive_and_compare("output clamp high", 100, 0, 1'b0, res);
        check_sample("output limit up", 500, res);
    endtask

    task automatic hold_blocking_result();
        pid_pkg::sample_t expected;
        pid_pkg::sample_t res;
        int latency;
        int held;
        int n;
        set_limits(`PID_LIMIT_MAX, -`PID_LIMIT_MAX, `PID_LIMIT_MAX, -`PID_LIMIT_MAX);
        set_params(3, 1, 2, 1, 2, 1);
        model_step(1200, -300, expected);
        run_sample(1200, -300, 1'b0, res, latency);
        check_sample("blocking result", expected, res);
        check_count("blocking latency", 3, latency);
        // A new request must not be accepted while the result is pending
        setpoint    = 77;
        measurement = 5;
        sample_req  = 1'b1;
        held = 0;
        n = 0;
        while (!sample_ack && n < 10) begin
            @(negedge clock);
            n++;
            if (result_req) held++;
        end
        check_count("blocking back-pressure", 0, int'(sample_ack));
        check_count("blocking result hold", 10, held);
        // The held request is taken once the result is acknowledged
        acknowledge_result();
        drive_and_compare("blocking after ack", 77, 5, 1'b0, res);
    endtask

    task automatic stream_nonblocking_results();
        pid_pkg::sample_t res;
        bus_write(pid_pkg::REG_FLAG, 32'd1);
        repeat (6) begin
            drive_and_compare("nonblocking", $random(seed) % 4000, $random(seed) % 4000,
                              1'b1, res);
        end
    endtask

    initial begin
        reset           = 1'b0;
        sb_address      = '0;
        sb_write_data   = '0;
        sb_write_strobe = 1'b0;
        sb_read_strobe  = 1'b0;
        setpoint        = '0;
        measurement     = '0;
        sample_req      = 1'b0;
        result_ack      = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        read_reset_values();
        sweep_register_map();
        run_p_and_d_paths();
        saturate_integrator();
        hold_blocking_result();
        stream_nonblocking_results();

        $display("Summary: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* design/pid_subsystem.sv */
////////////////////////////////////////////////////////////
// PID controller top with register bus and sample ports
// Latencies are those of the control unit and the core
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pid_subsystem (
    input  logic              clock,
    input  logic              reset,
    input  logic [31:0]       sb_address,
    input  logic [31:0]       sb_write_data,
    input  logic              sb_write_strobe,
    input  logic              sb_read_strobe,
    output logic [31:0]       sb_read_data,
    output logic              sb_read_valid,
    output logic              sb_ready,
    input  pid_pkg::sample_t  setpoint,
    input  pid_pkg::sample_t  measurement,
    input  logic              sample_req,
    output logic              sample_ack,
    output pid_pkg::sample_t  result,
    output logic              result_req,
    input  logic              result_ack
);

    logic              nonblocking_output;
    pid_pkg::gain_t    kp;
    pid_pkg::gain_t    ki;
    pid_pkg::gain_t    kd;
    pid_pkg::shift_t   kp_den;
    pid_pkg::shift_t   ki_den;
    pid_pkg::shift_t   kd_den;
    pid_pkg::sample_t  limit_out_up;
    pid_pkg::sample_t  limit_out_down;
    pid_pkg::sample_t  limit_int_up;
    pid_pkg::sample_t  limit_int_down;

    pid_control_unit u_control_unit (
        .clock              (clock),
        .reset              (reset),
        .sb_address         (sb_address),
        .sb_write_data      (sb_write_data),
        .sb_write_strobe    (sb_write_strobe),
        .sb_read_strobe     (sb_read_strobe),
        .sb_read_data       (sb_read_data),
        .sb_read_valid      (sb_read_valid),
        .sb_ready           (sb_ready),
        .nonblocking_output (nonblocking_output),
        .kp                 (kp),
        .kp_den             (kp_den),
        .ki                 (ki),
        .ki_den             (ki_den),
        .kd                 (kd),
        .kd_den             (kd_den),
        .limit_out_up       (limit_out_up),
        .limit_out_down     (limit_out_down),
        .limit_int_up       (limit_int_up),
        .limit_int_down     (limit_int_down)
    );

    pid_core u_core (
        .clock              (clock),
        .reset              (reset),
        .nonblocking_output (nonblocking_output),
        .kp                 (kp),
        .kp_den             (kp_den),
        .ki                 (ki),
        .ki_den             (ki_den),
        .kd                 (kd),
        .kd_den             (kd_den),
        .limit_out_up       (limit_out_up),
        .limit_out_down     (limit_out_down),
        .limit_int_up       (limit_int_up),
        .limit_int_down     (limit_int_down),
        .setpoint           (setpoint),
        .measurement        (measurement),
        .sample_req         (sample_req),
        .sample_ack         (sample_ack),
        .result             (result),
        .result_req         (result_req),
        .result_ack         (result_ack)
    );

endmodule

/* design/pid_core.sv */
////////////////////////////////////////////////////////////
// PID arithmetic for one sample at a time
// result_req rises three cycles after sample_ack
// Parameters are read live and must not change mid-sample
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pid_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              nonblocking_output,
    input  pid_pkg::gain_t    kp,
    input  pid_pkg::shift_t   kp_den,
    input  pid_pkg::gain_t    ki,
    input  pid_pkg::shift_t   ki_den,
    input  pid_pkg::gain_t    kd,
    input  pid_pkg::shift_t   kd_den,
    input  pid_pkg::sample_t  limit_out_up,
    input  pid_pkg::sample_t  limit_out_down,
    input  pid_pkg::sample_t  limit_int_up,
    input  pid_pkg::sample_t  limit_int_down,
    input  pid_pkg::sample_t  setpoint,
    input  pid_pkg::sample_t  measurement,
    input  logic              sample_req,
    output logic              sample_ack,
    output pid_pkg::sample_t  result,
    output logic              result_req,
    input  logic              result_ack
);

    typedef enum logic [2:0] {
        IDLE,
        STAGE_ERROR,
        STAGE_TERMS,
        STAGE_SUM,
        RESULT_HANDSHAKE,
        WAIT_DROP
    } state_e;

    state_e            state;
    pid_pkg::sample_t  setpoint_q;
    pid_pkg::sample_t  measurement_q;
    pid_pkg::acc_t     error;
    pid_pkg::acc_t     prev_error;
    pid_pkg::acc_t     integrator;
    pid_pkg::acc_t     p_term;
    pid_pkg::acc_t     d_term;
    pid_pkg::acc_t     int_next;
    pid_pkg::acc_t     p_calc;
    pid_pkg::acc_t     d_calc;
    pid_pkg::acc_t     ki_term;
    pid_pkg::acc_t     int_sum;
    pid_pkg::acc_t     int_clamped;
    pid_pkg::acc_t     out_sum;
    pid_pkg::acc_t     out_clamped;

    // Term products
    always_comb begin
        p_calc  = (pid_pkg::acc_t'(kp) * error) >>> kp_den;
        ki_term = (pid_pkg::acc_t'(ki) * error) >>> ki_den;
        d_calc  = (pid_pkg::acc_t'(kd) * (error - prev_error)) >>> kd_den;
    end

    // Integrator update with saturation
    always_comb begin
        int_sum = integrator + ki_term;
        if (int_sum > pid_pkg::acc_t'(limit_int_up)) begin
            int_clamped = pid_pkg::acc_t'(limit_int_up);
        end else if (int_sum < pid_pkg::acc_t'(limit_int_down)) begin
            int_clamped = pid_pkg::acc_t'(limit_int_down);
        end else begin
            int_clamped = int_sum;
        end
    end

    // Output sum with saturation
    always_comb begin
        out_sum = p_term + int_next + d_term;
        if (out_sum > pid_pkg::acc_t'(limit_out_up)) begin
            out_clamped = pid_pkg::acc_t'(limit_out_up);
        end else if (out_sum < pid_pkg::acc_t'(limit_out_down)) begin
            out_clamped = pid_pkg::acc_t'(limit_out_down);
        end else begin
            out_clamped = out_sum;
        end
    end

    // Pipeline payload
    always_ff @(posedge clock) begin
        if (state == IDLE && sample_req && !sample_ack) begin
            setpoint_q    <= setpoint;
            measurement_q <= measurement;
        end
        if (state == STAGE_ERROR) begin
            error <= pid_pkg::acc_t'(setpoint_q) - pid_pkg::acc_t'(measurement_q);
        end
        if (state == STAGE_TERMS) begin
            p_term   <= p_calc;
            d_term   <= d_calc;
            int_next <= int_clamped;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= IDLE;
            sample_ack <= 1'b0;
            result_req <= 1'b0;
            result     <= '0;
            integrator <= '0;
            prev_error <= '0;
        end else begin
            // Input handshake completes independently of the compute
            if (sample_ack && !sample_req) begin
                sample_ack <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (sample_req && !sample_ack) begin
                        sample_ack <= 1'b1;
                        state      <= STAGE_ERROR;
                    end
                end
                STAGE_ERROR: state <= STAGE_TERMS;
                STAGE_TERMS: state <= STAGE_SUM;
                STAGE_SUM: begin
                    result     <= pid_pkg::sample_t'(out_clamped);
                    result_req <= 1'b1;
                    integrator <= int_next;
                    prev_error <= error;
                    state      <= nonblocking_output ? WAIT_DROP : RESULT_HANDSHAKE;
                end
                RESULT_HANDSHAKE: begin
                    if (result_ack) begin
                        result_req <= 1'b0;
                        state      <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // Ends the one-cycle pulse in non-blocking mode
                    result_req <= 1'b0;
                    if (nonblocking_output || !result_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* design/pid_control_unit.sv */
////////////////////////////////////////////////////////////
// Parameter registers behind the strobe/ready bus
// A write keeps sb_ready low for two cycles
// Reads answer one cycle after the strobe and win over writes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pid_settings.svh"

module pid_control_unit (
    input  logic              clock,
    input  logic              reset,
    input  logic [31:0]       sb_address,
    input  logic [31:0]       sb_write_data,
    input  logic              sb_write_strobe,
    input  logic              sb_read_strobe,
    output logic [31:0]       sb_read_data,
    output logic              sb_read_valid,
    output logic              sb_ready,
    output logic              nonblocking_output,
    output pid_pkg::gain_t    kp,
    output pid_pkg::shift_t   kp_den,
    output pid_pkg::gain_t    ki,
    output pid_pkg::shift_t   ki_den,
    output pid_pkg::gain_t    kd,
    output pid_pkg::shift_t   kd_den,
    output pid_pkg::sample_t  limit_out_up,
    output pid_pkg::sample_t  limit_out_down,
    output pid_pkg::sample_t  limit_int_up,
    output pid_pkg::sample_t  limit_int_down
);

    localparam int DW = `PID_DATA_WIDTH;

    typedef enum logic {
        IDLE,
        ACT
    } state_e;

    state_e      state;
    logic        write_done;
    logic [31:0] latched_offset;
    logic [31:0] latched_data;
    logic [31:0] read_offset;
    logic [31:0] read_mux;

    assign read_offset = sb_address - `PID_BASE_ADDRESS;

    // Readback with gains zero-extended and limits sign-extended
    always_comb begin
        case (read_offset)
            pid_pkg::REG_FLAG:           read_mux = 32'(nonblocking_output);
            pid_pkg::REG_KP:             read_mux = 32'(kp);
            pid_pkg::REG_KI:             read_mux = 32'(ki);
            pid_pkg::REG_KD:             read_mux = 32'(kd);
            pid_pkg::REG_LIMIT_OUT_UP:   read_mux = 32'(limit_out_up);
            pid_pkg::REG_LIMIT_OUT_DOWN: read_mux = 32'(limit_out_down);
            pid_pkg::REG_LIMIT_INT_UP:   read_mux = 32'(limit_int_up);
            pid_pkg::REG_LIMIT_INT_DOWN: read_mux = 32'(limit_int_down);
            pid_pkg::REG_DEN:            read_mux = {8'd0, kd_den, ki_den, kp_den};
            default:                     read_mux = 32'd0;
        endcase
    end

    // Capture the write for the act state
    always_ff @(posedge clock) begin
        if (state == IDLE && sb_write_strobe && !sb_read_strobe) begin
            latched_offset <= sb_address - `PID_BASE_ADDRESS;
            latched_data   <= sb_write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state              <= IDLE;
            write_done         <= 1'b0;
            sb_ready           <= 1'b1;
            sb_read_valid      <= 1'b0;
            sb_read_data       <= 32'd0;
            nonblocking_output <= 1'b0;
            kp                 <= '0;
            ki                 <= '0;
            kd                 <= '0;
            kp_den             <= '0;
            ki_den             <= '0;
            kd_den             <= '0;
            limit_out_up       <= pid_pkg::sample_t'(`PID_LIMIT_MAX);
            limit_out_down     <= pid_pkg::sample_t'(-`PID_LIMIT_MAX);
            limit_int_up       <= pid_pkg::sample_t'(`PID_LIMIT_MAX);
            limit_int_down     <= pid_pkg::sample_t'(-`PID_LIMIT_MAX);
        end else begin
            sb_read_valid <= 1'b0;
            sb_read_data  <= 32'd0;
            case (state)
                IDLE: begin
                    if (sb_read_strobe) begin
                        sb_read_valid <= 1'b1;
                        sb_read_data  <= read_mux;
                    end else if (sb_write_strobe) begin
                        sb_ready <= 1'b0;
                        state    <= ACT;
                    end
                end
                ACT: begin
                    if (write_done) begin
                        // Second act cycle releases the bus
                        write_done <= 1'b0;
                        sb_ready   <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        write_done <= 1'b1;
                        case (latched_offset)
                            pid_pkg::REG_FLAG:   nonblocking_output <= latched_data[0];
                            pid_pkg::REG_KP:     kp <= pid_pkg::gain_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_KI:     ki <= pid_pkg::gain_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_KD:     kd <= pid_pkg::gain_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_LIMIT_OUT_UP:
                                limit_out_up <= pid_pkg::sample_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_LIMIT_OUT_DOWN:
                                limit_out_down <= pid_pkg::sample_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_LIMIT_INT_UP:
                                limit_int_up <= pid_pkg::sample_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_LIMIT_INT_DOWN:
                                limit_int_down <= pid_pkg::sample_t'(latched_data[DW-1:0]);
                            pid_pkg::REG_DEN: begin
                                kp_den <= latched_data[7:0];
                                ki_den <= latched_data[15:8];
                                kd_den <= latched_data[23:16];
                            end
                            default: ;
                        endcase
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* design/pid_pkg.sv */
////////////////////////////////////////////////////////////
// Types shared by the PID register block and core
// Widths follow PID_DATA_WIDTH from the settings header
////////////////////////////////////////////////////////////

`include "pid_settings.svh"

package pid_pkg;

    // Setpoint, measurement, result and limits
    typedef logic signed [`PID_DATA_WIDTH-1:0] sample_t;

    // Unsigned gains kP, kI and kD
    typedef logic [`PID_DATA_WIDTH-1:0] gain_t;

    // Right-shift count for the gain denominators
    typedef logic [7:0] shift_t;

    // Internal term width with headroom for every product and sum
    typedef logic signed [2*`PID_DATA_WIDTH+3:0] acc_t;

    typedef enum logic [31:0] {
        REG_FLAG           = 32'h00,
        REG_KP             = 32'h04,
        REG_KI             = 32'h08,
        REG_KD             = 32'h0C,
        REG_LIMIT_OUT_UP   = 32'h10,
        REG_LIMIT_OUT_DOWN = 32'h14,
        REG_LIMIT_INT_UP   = 32'h18,
        REG_LIMIT_INT_DOWN = 32'h1C,
        REG_DEN            = 32'h20
    } reg_offset_e;

endpackage

/* design/pid_settings.svh */
////////////////////////////////////////////////////////////
// Build-time constants for the PID controller
// PID_DATA_WIDTH may range up to 24 with the 32-bit bus
// Limits reset to plus and minus PID_LIMIT_MAX
////////////////////////////////////////////////////////////

`ifndef PID_SETTINGS_SVH
`define PID_SETTINGS_SVH

// Sample and gain width
`define PID_DATA_WIDTH 16

// Bus address of register offset zero
`define PID_BASE_ADDRESS 32'h43c00000

`define PID_LIMIT_MAX 32767

`endif
